//--- Bender.yml
package:
  name: cache_interface

sources:
  - mem_map_pkg.sv
  - io_bus_pkg.sv
  - cache_core.sv
  - cache_nocache.sv
  - cache_interface.sv
  - target: simulation
    files:
      - axi_io_mem_model.sv
      - tb_cache_interface.sv

//--- axi_io_mem_model.sv
/*
 * memory model behind the line-wide bus: shadow memory for the three
 * regions, programmable ready delay and transfer counters per region
 */
`timescale 1ns/1ns

module axi_io_mem_model (
  input  logic                             clk,
  input  logic                             i_valid,
  input  io_bus_pkg::bus_op_t              i_op,
  input  logic [io_bus_pkg::LINE_BITS-1:0] i_wdata,
  input  logic [63:0]                      i_addr,
  input  io_bus_pkg::bus_size_t            i_size,
  input  logic [7:0]                       i_blks,
  input  logic [2:0]                       i_delay,
  output logic                             o_ready,
  output logic [io_bus_pkg::LINE_BITS-1:0] o_rdata
);
  import io_bus_pkg::*;
  import mem_map_pkg::*;

  // 4 KiB window per region
  localparam int WIN = 4096;

  logic [7:0] mem [0:3*WIN-1];
  int         rd_count [3];
  int         wr_count [3];
  bus_size_t  last_size;
  logic [7:0] last_blks;
  logic       active;
  logic [2:0] wait_cnt;

  function automatic int slot_of(input logic [31:0] a);
    case (a[31:28])
      REGION_UART:  return 0;
      REGION_FLASH: return 1;
      default:      return 2;
    endcase
  endfunction

  function automatic int index_of(input logic [31:0] a);
    return slot_of(a) * WIN + int'(a[11:0]);
  endfunction

  initial begin : fill
    logic [31:0] a;
    logic [3:0]  code;
    for (int s = 0; s < 3; s++) begin
      code = (s == 0) ? REGION_UART : (s == 1) ? REGION_FLASH : REGION_MEM;
      for (int off = 0; off < WIN; off++) begin
        a = {code, 16'h0000, off[11:0]};
        mem[s*WIN + off] = a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'ha5;
      end
      rd_count[s] = 0;
      wr_count[s] = 0;
    end
    o_ready   = 1'b0;
    o_rdata   = '0;
    active    = 1'b0;
    wait_cnt  = 3'd0;
    last_size = SIZE_B1;
    last_blks = 8'd0;
  end

  //////////////////////////////////////////////////
  // ready after i_delay cycles, one transfer per valid

  always @(negedge clk) begin : xfer
    logic [31:0] a;
    int          n;
    if (o_ready) begin
      o_ready = 1'b0;
      active  = 1'b0;
    end else if (i_valid) begin
      if (!active) begin
        active   = 1'b1;
        wait_cnt = i_delay;
      end
      if (wait_cnt != 3'd0) begin
        wait_cnt = wait_cnt - 3'd1;
      end else begin
        a         = i_addr[31:0];
        n         = (i_blks != 8'd0) ? (int'(i_blks) + 1) * 8 : 1 << i_size;
        last_size = i_size;
        last_blks = i_blks;
        o_rdata   = '0;
        for (int k = 0; k < n; k++) begin
          if (i_op == OP_WRITE) begin
            mem[index_of(a + k)] = i_wdata[k*8 +: 8];
          end else begin
            o_rdata[k*8 +: 8] = mem[index_of(a + k)];
          end
        end
        if (i_op == OP_WRITE) begin
          wr_count[slot_of(a)] = wr_count[slot_of(a)] + 1;
        end else begin
          rd_count[slot_of(a)] = rd_count[slot_of(a)] + 1;
        end
        o_ready = 1'b1;
      end
    end
  end

endmodule

//--- cache_core.sv
/*
 * direct-mapped write-back cache, 16 lines of 128 bits,
 * refilling and writing back whole lines over the memory bus
 */
`timescale 1ns/1ns

module cache_core (
  input  logic                             clk,
  input  logic                             i_reset,
  input  logic                             i_core_req,
  input  logic [63:0]                      i_core_addr,
  input  io_bus_pkg::bus_op_t              i_core_op,
  input  io_bus_pkg::req_bytes_t           i_core_bytes,
  input  logic [63:0]                      i_core_wdata,
  output logic                             o_core_ack,
  output logic [63:0]                      o_core_rdata,
  input  logic [io_bus_pkg::LINE_BITS-1:0] i_axi_io_rdata,
  input  logic                             i_axi_io_ready,
  output logic                             o_axi_io_valid,
  output io_bus_pkg::bus_op_t              o_axi_io_op,
  output logic [io_bus_pkg::LINE_BITS-1:0] o_axi_io_wdata,
  output logic [63:0]                      o_axi_io_addr,
  output io_bus_pkg::bus_size_t            o_axi_io_size,
  output logic [7:0]                       o_axi_io_blks
);
  import io_bus_pkg::*;
  import mem_map_pkg::*;

  localparam int LINES = 1 << INDEX_BITS;

  localparam logic [2:0] S_IDLE   = 3'd0;
  localparam logic [2:0] S_LOOKUP = 3'd1;
  localparam logic [2:0] S_WBACK  = 3'd2;
  localparam logic [2:0] S_REFILL = 3'd3;
  localparam logic [2:0] S_RESP   = 3'd4;

  logic [2:0]             state;
  logic                   bus_valid;
  logic [LINES-1:0]       valid_bits;
  logic [LINES-1:0]       dirty_bits;
  logic [TAG_BITS-1:0]    tag_mem [LINES];
  logic [LINE_BITS-1:0]   data_mem [LINES];

  // latched request
  logic [63:0]            req_addr_q;
  bus_op_t                req_op_q;
  req_bytes_t             req_bytes_q;
  logic [63:0]            req_wdata_q;

  mem_addr_t              req_view;
  logic [INDEX_BITS-1:0]  idx;
  logic [OFFSET_BITS-1:0] off;
  logic                   hit;
  logic                   access_now;
  logic                   fill_done;
  logic [LINE_BITS-1:0]   cur_line;
  logic [LINE_BITS-1:0]   wdata_shifted;
  logic [LINE_BITS-1:0]   merged_line;
  logic [63:0]            slot_word;

  assign req_view   = req_addr_q[31:0];
  assign idx        = req_view.line.index;
  assign off        = req_view.line.offset;
  assign cur_line   = data_mem[idx];
  assign hit        = valid_bits[idx] && (tag_mem[idx] == req_view.line.tag);
  assign access_now = (state == S_LOOKUP && hit) || state == S_RESP;
  assign fill_done  = state == S_REFILL && bus_valid && i_axi_io_ready;

  //////////////////////////////////////////////////
  // read and write on the resident line

  // aligned 8-byte slot, addressed byte moved to bit 0
  assign slot_word    = cur_line[off[3]*64 +: 64];
  assign o_core_rdata = slot_word >> {off[2:0], 3'b000};
  assign o_core_ack   = access_now;

  assign wdata_shifted = LINE_BITS'(req_wdata_q) << {off, 3'b000};

  always_comb begin
    merged_line = cur_line;
    for (int b = 0; b < LINE_BITS / 8; b++) begin
      if (b >= off && b <= off + req_bytes_q) begin
        merged_line[b*8 +: 8] = wdata_shifted[b*8 +: 8];
      end
    end
  end

  //////////////////////////////////////////////////
  // bus side

  assign o_axi_io_valid = bus_valid;
  assign o_axi_io_op    = (state == S_WBACK) ? OP_WRITE : OP_READ;
  assign o_axi_io_wdata = cur_line;
  assign o_axi_io_size  = SIZE_B8;
  assign o_axi_io_blks  = LINE_BLKS;

  // victim line address on write-back, requested line on refill
  assign o_axi_io_addr = (state == S_WBACK) ?
    {req_addr_q[63:32], tag_mem[idx], idx, {OFFSET_BITS{1'b0}}} :
    {req_addr_q[63:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

  //////////////////////////////////////////////////
  // FSM

  always_ff @(posedge clk) begin
    if (i_reset) begin
      state      <= S_IDLE;
      bus_valid  <= 1'b0;
      valid_bits <= '0;
      dirty_bits <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (i_core_req) begin
            state <= S_LOOKUP;
          end
        end
        S_LOOKUP: begin
          if (hit) begin
            state <= S_IDLE;
          end else begin
            bus_valid <= 1'b1;
            state     <= (valid_bits[idx] && dirty_bits[idx]) ? S_WBACK : S_REFILL;
          end
        end
        S_WBACK: begin
          // valid stays low for one cycle before the refill
          if (i_axi_io_ready) begin
            bus_valid       <= 1'b0;
            dirty_bits[idx] <= 1'b0;
            state           <= S_REFILL;
          end
        end
        S_REFILL: begin
          if (!bus_valid) begin
            bus_valid <= 1'b1;
          end else if (i_axi_io_ready) begin
            bus_valid       <= 1'b0;
            valid_bits[idx] <= 1'b1;
            state           <= S_RESP;
          end
        end
        S_RESP: begin
          state <= S_IDLE;
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
      if (access_now && req_op_q == OP_WRITE) begin
        dirty_bits[idx] <= 1'b1;
      end
    end
  end

  // request latch and line storage
  always_ff @(posedge clk) begin
    if (state == S_IDLE && i_core_req) begin
      req_addr_q  <= i_core_addr;
      req_op_q    <= i_core_op;
      req_bytes_q <= i_core_bytes;
      req_wdata_q <= i_core_wdata;
    end
    if (fill_done) begin
      data_mem[idx] <= i_axi_io_rdata;
      tag_mem[idx]  <= req_view.line.tag;
    end else if (access_now && req_op_q == OP_WRITE) begin
      data_mem[idx] <= merged_line;
    end
  end

endmodule

//--- cache_interface.f
mem_map_pkg.sv
io_bus_pkg.sv
cache_core.sv
cache_nocache.sv
cache_interface.sv
axi_io_mem_model.sv
tb_cache_interface.sv

//--- cache_interface.sv
/*
 * memory access front end: steers instruction and data requests to
 * the two caches or the uncached path and shares one bus between them
 */
`timescale 1ns/1ns

module cache_interface #(
  parameter bit CACHE_FLASH = 1'b0
) (
  input  logic                             clk,
  input  logic                             i_reset,
  input  logic                             i_icache_req,
  input  logic [63:0]                      i_icache_addr,
  output logic                             o_icache_ack,
  output logic [31:0]                      o_icache_rdata,
  input  logic                             i_dcache_req,
  input  logic [63:0]                      i_dcache_addr,
  input  io_bus_pkg::bus_op_t              i_dcache_op,
  input  io_bus_pkg::req_bytes_t           i_dcache_bytes,
  input  logic [63:0]                      i_dcache_wdata,
  output logic                             o_dcache_ack,
  output logic [63:0]                      o_dcache_rdata,
  input  logic [io_bus_pkg::LINE_BITS-1:0] i_axi_io_rdata,
  input  logic                             i_axi_io_ready,
  output logic                             o_axi_io_valid,
  output io_bus_pkg::bus_op_t              o_axi_io_op,
  output logic [io_bus_pkg::LINE_BITS-1:0] o_axi_io_wdata,
  output logic [63:0]                      o_axi_io_addr,
  output io_bus_pkg::bus_size_t            o_axi_io_size,
  output logic [7:0]                       o_axi_io_blks
);
  import io_bus_pkg::*;
  import mem_map_pkg::*;

  localparam logic [1:0] OWN_NONE = 2'd0;
  localparam logic [1:0] OWN_I    = 2'd1;
  localparam logic [1:0] OWN_D    = 2'd2;
  localparam logic [1:0] OWN_NC   = 2'd3;

  function automatic logic is_cached(input logic [3:0] region);
    return region == REGION_MEM || (CACHE_FLASH && region == REGION_FLASH);
  endfunction

  function automatic logic is_uncached(input logic [3:0] region);
    return region == REGION_UART || (!CACHE_FLASH && region == REGION_FLASH);
  endfunction

  mem_addr_t            iaddr;
  mem_addr_t            daddr;
  logic                 i_to_cache, i_to_nc, d_to_cache, d_to_nc;
  logic                 i_nc_want, d_nc_want;
  logic                 nc_hold_q, nc_port_d_q, nc_pick_d;
  logic [1:0]           owner_q, owner_sel;
  logic                 gap_q;
  logic                 bus_ready;

  // per-path bus masters
  logic                 ic_valid, dc_valid, nc_valid;
  bus_op_t              ic_op, dc_op, nc_op;
  logic [LINE_BITS-1:0] ic_wdata, dc_wdata, nc_wdata;
  logic [63:0]          ic_addr, dc_addr, nc_addr;
  bus_size_t            ic_size, dc_size, nc_size;
  logic [7:0]           ic_blks, dc_blks, nc_blks;
  logic                 ic_ack, dc_ack, nc_ack;
  logic [63:0]          ic_rdata, dc_rdata, nc_rdata;

  //////////////////////////////////////////////////
  // region decode

  assign iaddr      = i_icache_addr[31:0];
  assign daddr      = i_dcache_addr[31:0];
  assign i_to_cache = is_cached(iaddr.rgn.region);
  assign i_to_nc    = is_uncached(iaddr.rgn.region);
  assign d_to_cache = is_cached(daddr.rgn.region);
  assign d_to_nc    = is_uncached(daddr.rgn.region);
  assign i_nc_want  = i_icache_req && i_to_nc;
  assign d_nc_want  = i_dcache_req && d_to_nc;

  // uncached path, instruction port first
  assign nc_pick_d = nc_hold_q ? nc_port_d_q : !i_nc_want;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      nc_hold_q   <= 1'b0;
      nc_port_d_q <= 1'b0;
    end else begin
      nc_port_d_q <= nc_pick_d;
      if (nc_ack) begin
        nc_hold_q <= 1'b0;
      end else if (i_nc_want || d_nc_want) begin
        nc_hold_q <= 1'b1;
      end
    end
  end

  assign o_icache_ack   = ic_ack || (nc_ack && !nc_port_d_q);
  assign o_dcache_ack   = dc_ack || (nc_ack && nc_port_d_q);
  assign o_icache_rdata = i_to_cache ? ic_rdata[31:0] : nc_rdata[31:0];
  assign o_dcache_rdata = d_to_cache ? dc_rdata : nc_rdata;

  //////////////////////////////////////////////////
  // bus owner

  always_comb begin
    owner_sel = owner_q;
    if (gap_q) begin
      owner_sel = OWN_NONE;
    end else if (owner_q == OWN_NONE) begin
      if (ic_valid) begin
        owner_sel = OWN_I;
      end else if (dc_valid) begin
        owner_sel = OWN_D;
      end else if (nc_valid) begin
        owner_sel = OWN_NC;
      end
    end
  end

  assign bus_ready = i_axi_io_ready && owner_sel != OWN_NONE;

  // one idle cycle on the bus after each ready
  always_ff @(posedge clk) begin
    if (i_reset) begin
      owner_q <= OWN_NONE;
      gap_q   <= 1'b0;
    end else begin
      gap_q   <= bus_ready;
      owner_q <= bus_ready ? OWN_NONE : owner_sel;
    end
  end

  always_comb begin
    case (owner_sel)
      OWN_I:   {o_axi_io_op, o_axi_io_wdata, o_axi_io_addr, o_axi_io_size, o_axi_io_blks} =
                 {ic_op, ic_wdata, ic_addr, ic_size, ic_blks};
      OWN_D:   {o_axi_io_op, o_axi_io_wdata, o_axi_io_addr, o_axi_io_size, o_axi_io_blks} =
                 {dc_op, dc_wdata, dc_addr, dc_size, dc_blks};
      default: {o_axi_io_op, o_axi_io_wdata, o_axi_io_addr, o_axi_io_size, o_axi_io_blks} =
                 {nc_op, nc_wdata, nc_addr, nc_size, nc_blks};
    endcase
  end
  assign o_axi_io_valid = owner_sel != OWN_NONE;

  //////////////////////////////////////////////////
  // paths

  cache_core u_icache (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_core_req     (i_icache_req && i_to_cache),
    .i_core_addr    (i_icache_addr),
    .i_core_op      (OP_READ),
    .i_core_bytes   (3'd3),
    .i_core_wdata   (64'd0),
    .o_core_ack     (ic_ack),
    .o_core_rdata   (ic_rdata),
    .i_axi_io_rdata ((owner_sel == OWN_I) ? i_axi_io_rdata : '0),
    .i_axi_io_ready (i_axi_io_ready && owner_sel == OWN_I),
    .o_axi_io_valid (ic_valid),
    .o_axi_io_op    (ic_op),
    .o_axi_io_wdata (ic_wdata),
    .o_axi_io_addr  (ic_addr),
    .o_axi_io_size  (ic_size),
    .o_axi_io_blks  (ic_blks)
  );

  cache_core u_dcache (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_core_req     (i_dcache_req && d_to_cache),
    .i_core_addr    (i_dcache_addr),
    .i_core_op      (i_dcache_op),
    .i_core_bytes   (i_dcache_bytes),
    .i_core_wdata   (i_dcache_wdata),
    .o_core_ack     (dc_ack),
    .o_core_rdata   (dc_rdata),
    .i_axi_io_rdata ((owner_sel == OWN_D) ? i_axi_io_rdata : '0),
    .i_axi_io_ready (i_axi_io_ready && owner_sel == OWN_D),
    .o_axi_io_valid (dc_valid),
    .o_axi_io_op    (dc_op),
    .o_axi_io_wdata (dc_wdata),
    .o_axi_io_addr  (dc_addr),
    .o_axi_io_size  (dc_size),
    .o_axi_io_blks  (dc_blks)
  );

  cache_nocache u_nocache (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_nc_req       (i_nc_want || d_nc_want),
    .i_nc_addr      (nc_pick_d ? i_dcache_addr : i_icache_addr),
    .i_nc_op        (nc_pick_d ? i_dcache_op : OP_READ),
    .i_nc_bytes     (nc_pick_d ? i_dcache_bytes : 3'd3),
    .i_nc_wdata     (nc_pick_d ? i_dcache_wdata : 64'd0),
    .o_nc_ack       (nc_ack),
    .o_nc_rdata     (nc_rdata),
    .i_axi_io_rdata ((owner_sel == OWN_NC) ? i_axi_io_rdata : '0),
    .i_axi_io_ready (i_axi_io_ready && owner_sel == OWN_NC),
    .o_axi_io_valid (nc_valid),
    .o_axi_io_op    (nc_op),
    .o_axi_io_wdata (nc_wdata),
    .o_axi_io_addr  (nc_addr),
    .o_axi_io_size  (nc_size),
    .o_axi_io_blks  (nc_blks)
  );

endmodule

//--- cache_nocache.sv
/*
 * uncached path: one registered request, one single-beat bus transfer
 */
`timescale 1ns/1ns

module cache_nocache (
  input  logic                             clk,
  input  logic                             i_reset,
  input  logic                             i_nc_req,
  input  logic [63:0]                      i_nc_addr,
  input  io_bus_pkg::bus_op_t              i_nc_op,
  input  io_bus_pkg::req_bytes_t           i_nc_bytes,
  input  logic [63:0]                      i_nc_wdata,
  output logic                             o_nc_ack,
  output logic [63:0]                      o_nc_rdata,
  input  logic [io_bus_pkg::LINE_BITS-1:0] i_axi_io_rdata,
  input  logic                             i_axi_io_ready,
  output logic                             o_axi_io_valid,
  output io_bus_pkg::bus_op_t              o_axi_io_op,
  output logic [io_bus_pkg::LINE_BITS-1:0] o_axi_io_wdata,
  output logic [63:0]                      o_axi_io_addr,
  output io_bus_pkg::bus_size_t            o_axi_io_size,
  output logic [7:0]                       o_axi_io_blks
);
  import io_bus_pkg::*;

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_BUS  = 2'd1;
  localparam logic [1:0] S_ACK  = 2'd2;

  logic [1:0]  state;
  logic [63:0] addr_q;
  bus_op_t     op_q;
  bus_size_t   size_q;
  logic [63:0] wdata_q;
  logic [63:0] rdata_q;

  // byte count to beat size
  function automatic bus_size_t bytes_to_size(input req_bytes_t bytes);
    case (bytes)
      3'd0:    return SIZE_B1;
      3'd1:    return SIZE_B2;
      3'd3:    return SIZE_B4;
      default: return SIZE_B8;
    endcase
  endfunction

  assign o_axi_io_valid = state == S_BUS;
  assign o_axi_io_op    = op_q;
  assign o_axi_io_addr  = addr_q;
  assign o_axi_io_size  = size_q;
  assign o_axi_io_blks  = 8'd0;
  // single beat, data in the low bytes
  assign o_axi_io_wdata = LINE_BITS'(wdata_q);

  assign o_nc_ack   = state == S_ACK;
  assign o_nc_rdata = rdata_q;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          if (i_nc_req) begin
            state <= S_BUS;
          end
        end
        S_BUS: begin
          if (i_axi_io_ready) begin
            state <= S_ACK;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && i_nc_req) begin
      addr_q  <= i_nc_addr;
      op_q    <= i_nc_op;
      size_q  <= bytes_to_size(i_nc_bytes);
      wdata_q <= i_nc_wdata;
    end
    if (state == S_BUS && i_axi_io_ready) begin
      rdata_q <= i_axi_io_rdata[63:0];
    end
  end

endmodule

//--- io_bus_pkg.sv
/*
 * line-wide memory bus definitions shared by the caches,
 * the uncached path and the bus bridge
 */
package io_bus_pkg;

  // one cache line per transfer
  localparam int LINE_BITS = 128;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bus_op_t;

  // beat size on the bus
  typedef enum logic [2:0] {
    SIZE_B1 = 3'd0,
    SIZE_B2 = 3'd1,
    SIZE_B4 = 3'd2,
    SIZE_B8 = 3'd3
  } bus_size_t;

  // request byte count minus one, legal values 0, 1, 3, 7
  typedef logic [2:0] req_bytes_t;

  // 64-bit beats per line minus one
  localparam logic [7:0] LINE_BLKS = 8'd1;

endpackage

//--- mem_map_pkg.sv
/*
 * memory map definitions: address regions, cache line geometry
 * and the two decoded views of the low address word
 */
package mem_map_pkg;

  // region codes in address bits 31..28
  localparam logic [3:0] REGION_UART  = 4'h1;
  localparam logic [3:0] REGION_FLASH = 4'h3;
  localparam logic [3:0] REGION_MEM   = 4'h8;

  // 16-byte lines, 16 lines per cache
  localparam int OFFSET_BITS = 4;
  localparam int INDEX_BITS  = 4;
  localparam int TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS;

  // router view
  typedef struct packed {
    logic [3:0]  region;
    logic [27:0] rest;
  } region_view_t;

  // cache view
  typedef struct packed {
    logic [TAG_BITS-1:0]    tag;
    logic [INDEX_BITS-1:0]  index;
    logic [OFFSET_BITS-1:0] offset;
  } line_view_t;

  typedef union packed {
    region_view_t rgn;
    line_view_t   line;
  } mem_addr_t;

endpackage

//--- tb_cache_interface.sv
/*
 * testbench for the memory access front end: uncached path, both
 * caches, line eviction and a shared flash access from both ports
 */
`timescale 1ns/1ns

module tb_cache_interface;
  import io_bus_pkg::*;
  import mem_map_pkg::*;

  localparam int SLOT_UART  = 0;
  localparam int SLOT_FLASH = 1;
  localparam int SLOT_MEM   = 2;
  localparam int WIN        = 4096;
  // worst case per request is two transfers of 8 cycles plus overhead
  localparam int NUM_REQS   = 18;
  localparam int MAX_CYCLES = NUM_REQS * 40;

  logic                 clk;
  logic                 i_reset;
  logic                 i_icache_req;
  logic [63:0]          i_icache_addr;
  logic                 o_icache_ack;
  logic [31:0]          o_icache_rdata;
  logic                 i_dcache_req;
  logic [63:0]          i_dcache_addr;
  bus_op_t              i_dcache_op;
  req_bytes_t           i_dcache_bytes;
  logic [63:0]          i_dcache_wdata;
  logic                 o_dcache_ack;
  logic [63:0]          o_dcache_rdata;
  logic [LINE_BITS-1:0] i_axi_io_rdata;
  logic                 i_axi_io_ready;
  logic                 o_axi_io_valid;
  bus_op_t              o_axi_io_op;
  logic [LINE_BITS-1:0] o_axi_io_wdata;
  logic [63:0]          o_axi_io_addr;
  bus_size_t            o_axi_io_size;
  logic [7:0]           o_axi_io_blks;
  logic [2:0]           ready_delay;

  // expected memory contents, same layout as the model
  logic [7:0]  ref_mem [0:3*WIN-1];
  logic [31:0] rng_state;
  int          cycles;
  int          checks;
  int          errors;

  cache_interface #(
    .CACHE_FLASH (1'b0)
  ) UUT (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_icache_req   (i_icache_req),
    .i_icache_addr  (i_icache_addr),
    .o_icache_ack   (o_icache_ack),
    .o_icache_rdata (o_icache_rdata),
    .i_dcache_req   (i_dcache_req),
    .i_dcache_addr  (i_dcache_addr),
    .i_dcache_op    (i_dcache_op),
    .i_dcache_bytes (i_dcache_bytes),
    .i_dcache_wdata (i_dcache_wdata),
    .o_dcache_ack   (o_dcache_ack),
    .o_dcache_rdata (o_dcache_rdata),
    .i_axi_io_rdata (i_axi_io_rdata),
    .i_axi_io_ready (i_axi_io_ready),
    .o_axi_io_valid (o_axi_io_valid),
    .o_axi_io_op    (o_axi_io_op),
    .o_axi_io_wdata (o_axi_io_wdata),
    .o_axi_io_addr  (o_axi_io_addr),
    .o_axi_io_size  (o_axi_io_size),
    .o_axi_io_blks  (o_axi_io_blks)
  );

  axi_io_mem_model u_mem (
    .clk     (clk),
    .i_valid (o_axi_io_valid),
    .i_op    (o_axi_io_op),
    .i_wdata (o_axi_io_wdata),
    .i_addr  (o_axi_io_addr),
    .i_size  (o_axi_io_size),
    .i_blks  (o_axi_io_blks),
    .i_delay (ready_delay),
    .o_ready (i_axi_io_ready),
    .o_rdata (i_axi_io_rdata)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: a request got no acknowledge within %0d cycles", MAX_CYCLES);
      $display("checks %0d, errors %0d", checks, errors + 1);
      $display("sim failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // helpers

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic logic [2:0] pick_delay();
    logic [31:0] r;
    r = next_rand();
    return r[18:16];
  endfunction

  function automatic int shadow_index(input logic [31:0] a);
    int slot;
    slot = (a[31:28] == REGION_UART) ? SLOT_UART :
           (a[31:28] == REGION_FLASH) ? SLOT_FLASH : SLOT_MEM;
    return slot * WIN + int'(a[11:0]);
  endfunction

  // n bytes from the reference, lowest address in the low byte
  function automatic logic [63:0] ref_bytes(input logic [31:0] a, input int n);
    logic [63:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v[k*8 +: 8] = ref_mem[shadow_index(a + k)];
    end
    return v;
  endfunction

  function automatic logic [63:0] model_dword(input logic [31:0] a);
    logic [63:0] v;
    for (int k = 0; k < 8; k++) begin
      v[k*8 +: 8] = u_mem.mem[shadow_index(a + k)];
    end
    return v;
  endfunction

  task automatic check_rdata32(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_rdata64(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_size(input string name, input bus_size_t got, input bus_size_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("error %s got %h expected %h", name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // request drivers, entered and left on a falling edge

  task automatic data_access(input logic [63:0] addr, input bus_op_t op,
                             input req_bytes_t bytes, input logic [63:0] wdata,
                             output logic [63:0] rdata);
    ready_delay    = pick_delay();
    i_dcache_req   = 1'b1;
    i_dcache_addr  = addr;
    i_dcache_op    = op;
    i_dcache_bytes = bytes;
    i_dcache_wdata = wdata;
    do begin
      @(negedge clk);
    end while (!o_dcache_ack);
    rdata = o_dcache_rdata;
    if (op == OP_WRITE) begin
      for (int k = 0; k <= int'(bytes); k++) begin
        ref_mem[shadow_index(addr[31:0] + k)] = wdata[k*8 +: 8];
      end
    end
    // hold through the ack cycle
    @(negedge clk);
    i_dcache_req = 1'b0;
  endtask

  task automatic fetch(input logic [63:0] addr, output logic [31:0] insn);
    ready_delay   = pick_delay();
    i_icache_req  = 1'b1;
    i_icache_addr = addr;
    do begin
      @(negedge clk);
    end while (!o_icache_ack);
    insn = o_icache_rdata;
    @(negedge clk);
    i_icache_req = 1'b0;
  endtask

  // both ports raised together, each dropped after its own ack
  task automatic fetch_and_load(input logic [63:0] iaddr, input logic [63:0] daddr,
                                output logic [31:0] insn, output logic [63:0] data);
    logic i_seen;
    logic d_seen;
    i_seen         = 1'b0;
    d_seen         = 1'b0;
    ready_delay    = pick_delay();
    i_icache_req   = 1'b1;
    i_icache_addr  = iaddr;
    i_dcache_req   = 1'b1;
    i_dcache_addr  = daddr;
    i_dcache_op    = OP_READ;
    i_dcache_bytes = 3'd7;
    i_dcache_wdata = 64'd0;
    while (i_icache_req || i_dcache_req) begin
      @(negedge clk);
      if (i_seen) begin
        i_icache_req = 1'b0;
      end
      if (d_seen) begin
        i_dcache_req = 1'b0;
      end
      if (!i_seen && o_icache_ack) begin
        insn   = o_icache_rdata;
        i_seen = 1'b1;
      end
      if (!d_seen && o_dcache_ack) begin
        data   = o_dcache_rdata;
        d_seen = 1'b1;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // tests

  task automatic test_uart();
    logic [63:0] rd;
    logic [63:0] wd;
    int          rd0;
    int          wr0;
    rd0 = u_mem.rd_count[SLOT_UART];
    wr0 = u_mem.wr_count[SLOT_UART];
    data_access(64'h1000_0004, OP_READ, 3'd3, 64'd0, rd);
    check_rdata64("uart o_dcache_rdata", rd, ref_bytes(32'h1000_0004, 4));
    check_size("uart read o_axi_io_size", u_mem.last_size, SIZE_B4);
    check_count("uart read o_axi_io_blks", int'(u_mem.last_blks), 0);
    wd = {next_rand(), next_rand()};
    data_access(64'h1000_0010, OP_WRITE, 3'd1, wd, rd);
    check_size("uart write o_axi_io_size", u_mem.last_size, SIZE_B2);
    check_count("uart write o_axi_io_blks", int'(u_mem.last_blks), 0);
    data_access(64'h1000_0010, OP_READ, 3'd1, 64'd0, rd);
    check_rdata64("uart readback o_dcache_rdata", rd, ref_bytes(32'h1000_0010, 2));
    check_count("uart read transfers", u_mem.rd_count[SLOT_UART] - rd0, 2);
    check_count("uart write transfers", u_mem.wr_count[SLOT_UART] - wr0, 1);
  endtask

  task automatic test_fetch();
    logic [31:0] insn;
    logic [63:0] exp;
    int          rd0;
    rd0 = u_mem.rd_count[SLOT_MEM];
    for (int k = 0; k < 4; k++) begin
      fetch(64'h8000_0040 + 4 * k, insn);
      exp = ref_bytes(32'h8000_0040 + 4 * k, 4);
      check_rdata32("fetch o_icache_rdata", insn, exp[31:0]);
      check_count("fetch line transfers", u_mem.rd_count[SLOT_MEM] - rd0, 1);
    end
  endtask

  task automatic test_data_merge();
    logic [63:0] rd;
    int          rd0;
    int          wr0;
    rd0 = u_mem.rd_count[SLOT_MEM];
    wr0 = u_mem.wr_count[SLOT_MEM];
    data_access(64'h8000_0081, OP_WRITE, 3'd0, {next_rand(), next_rand()}, rd);
    data_access(64'h8000_0082, OP_WRITE, 3'd1, {next_rand(), next_rand()}, rd);
    data_access(64'h8000_0084, OP_WRITE, 3'd3, {next_rand(), next_rand()}, rd);
    data_access(64'h8000_0088, OP_WRITE, 3'd7, {next_rand(), next_rand()}, rd);
    data_access(64'h8000_0080, OP_READ, 3'd7, 64'd0, rd);
    check_rdata64("merge low o_dcache_rdata", rd, ref_bytes(32'h8000_0080, 8));
    data_access(64'h8000_0088, OP_READ, 3'd7, 64'd0, rd);
    check_rdata64("merge high o_dcache_rdata", rd, ref_bytes(32'h8000_0088, 8));
    check_count("merge refills", u_mem.rd_count[SLOT_MEM] - rd0, 1);
    check_count("merge bus writes", u_mem.wr_count[SLOT_MEM] - wr0, 0);
  endtask

  task automatic test_eviction();
    logic [63:0] rd;
    logic [63:0] wd;
    int          rd0;
    int          wr0;
    // same index 1, tags differ
    wd = {next_rand(), next_rand()};
    data_access(64'h8000_0110, OP_WRITE, 3'd7, wd, rd);
    rd0 = u_mem.rd_count[SLOT_MEM];
    wr0 = u_mem.wr_count[SLOT_MEM];
    data_access(64'h8000_0210, OP_READ, 3'd7, 64'd0, rd);
    check_rdata64("evict o_dcache_rdata", rd, ref_bytes(32'h8000_0210, 8));
    check_count("evict write-backs", u_mem.wr_count[SLOT_MEM] - wr0, 1);
    check_count("evict refills", u_mem.rd_count[SLOT_MEM] - rd0, 1);
    check_rdata64("model memory after write-back", model_dword(32'h8000_0110), wd);
    data_access(64'h8000_0110, OP_READ, 3'd7, 64'd0, rd);
    check_rdata64("reread o_dcache_rdata", rd, wd);
  endtask

  task automatic test_flash_pair();
    logic [31:0] insn;
    logic [63:0] rd;
    logic [63:0] exp;
    int          rd0;
    rd0 = u_mem.rd_count[SLOT_FLASH];
    fetch_and_load(64'h3000_0020, 64'h3000_0048, insn, rd);
    exp = ref_bytes(32'h3000_0020, 4);
    check_rdata32("flash o_icache_rdata", insn, exp[31:0]);
    check_rdata64("flash o_dcache_rdata", rd, ref_bytes(32'h3000_0048, 8));
    check_count("flash transfers", u_mem.rd_count[SLOT_FLASH] - rd0, 2);
  endtask

  initial begin
    clk            = 1'b0;
    i_reset        = 1'b1;
    i_icache_req   = 1'b0;
    i_icache_addr  = 64'd0;
    i_dcache_req   = 1'b0;
    i_dcache_addr  = 64'd0;
    i_dcache_op    = OP_READ;
    i_dcache_bytes = 3'd0;
    i_dcache_wdata = 64'd0;
    ready_delay    = 3'd0;
    rng_state      = 32'h9640;
    cycles         = 0;
    checks         = 0;
    errors         = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    i_reset = 1'b0;
    for (int i = 0; i < 3 * WIN; i++) begin
      ref_mem[i] = u_mem.mem[i];
    end
    test_uart();
    test_fetch();
    test_data_merge();
    test_eviction();
    test_flash_pair();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
